// ==== hw/mem_pkg.sv ====
/*
 * Memory subsystem package
 * Fixed widths, pipeline latencies, clearing value and payload types
 */
package mem_pkg;

    // --------------------------------------------------
    // Array geometry
    // --------------------------------------------------
    localparam int ADDR_WID = 6;
    localparam int DEPTH    = 2**ADDR_WID;
    localparam int DATA_WID = 16;

    // Word written to every location after reset
    localparam logic [DATA_WID-1:0] RESET_VAL = 16'hA5A5;

    // --------------------------------------------------
    // Pipeline depths and latencies
    // --------------------------------------------------
    // Request stages ahead of the array write
    localparam int WR_PIPE_STAGES = 1;
    // Response stages after the array read register
    localparam int RD_PIPE_STAGES = 1;

    // Edges from acceptance to ack, array stage included
    localparam int WR_LATENCY = WR_PIPE_STAGES + 1;
    localparam int RD_LATENCY = RD_PIPE_STAGES + 1;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [ADDR_WID-1:0] addr_t;
    typedef logic [DATA_WID-1:0] data_t;

    // One pipelined write
    // ack_en is low for the writes of the clearing sequence
    typedef struct packed {
        logic  ack_en;
        addr_t addr;
        data_t data;
    } wr_req_t;

endpackage : mem_pkg

// ==== hw/mem_delay_pipe.sv ====
/*
 * Valid plus payload delay line, STAGES edges deep
 * Payload type is a parameter so one block serves requests and responses
 */
`timescale 1ns/1ps

module mem_delay_pipe #(
    parameter type T      = logic,
    parameter int  STAGES = 1
) (
    input  logic mem_if,
    input  logic rst_n,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    generate
        if (STAGES > 0) begin : g_pipe
            logic valid_q [STAGES];
            T     data_q  [STAGES];

            // Valid bits clear on reset
            always_ff @(posedge mem_if) begin
                if (!rst_n) begin
                    for (int i = 0; i < STAGES; i++) begin
                        valid_q[i] <= 1'b0;
                    end
                end else begin
                    valid_q[0] <= in_valid;
                    for (int i = 1; i < STAGES; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            // Payload shifts every edge
            always_ff @(posedge mem_if) begin
                data_q[0] <= in_data;
                for (int i = 1; i < STAGES; i++) begin
                    data_q[i] <= data_q[i-1];
                end
            end

            assign out_valid = valid_q[STAGES-1];
            assign out_data  = data_q[STAGES-1];
        end : g_pipe
        else begin : g_no_pipe
            // Zero stages, straight through
            assign out_valid = in_valid;
            assign out_data  = in_data;
        end : g_no_pipe
    endgenerate

endmodule : mem_delay_pipe

// ==== hw/mem_reset_fsm.sv ====
/*
 * Post-reset clearing sequencer
 * Writes RESET_VAL to every word, then forwards requests and raises rdy
 */
`timescale 1ns/1ps

module mem_reset_fsm (
    input  logic            mem_if,
    input  logic            rst_n,
    // Requester side
    input  logic            req,
    input  logic            wr,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::data_t  wr_data,
    output logic            rdy,
    // Array side
    output logic            ram_req,
    output logic            ram_wr,
    output logic            ram_ack_en,
    output mem_pkg::addr_t  ram_addr,
    output mem_pkg::data_t  ram_wr_data
);

    typedef enum logic {
        CLEARING = 1'b0,
        READY    = 1'b1
    } state_t;

    // --------------------------------------------------
    // State and clearing address
    // --------------------------------------------------
    state_t          state_q;
    mem_pkg::addr_t  clr_addr_q;
    logic            clr_last;

    assign clr_last = (clr_addr_q == mem_pkg::addr_t'(mem_pkg::DEPTH - 1));

    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            state_q    <= CLEARING;
            clr_addr_q <= '0;
        end else begin
            case (state_q)
                CLEARING: begin
                    // One word per edge, leave after the top address
                    clr_addr_q <= clr_addr_q + 1'b1;
                    if (clr_last) begin
                        state_q <= READY;
                    end
                end
                READY: begin
                    state_q <= READY;
                end
                default: begin
                    state_q <= CLEARING;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Request mux
    // --------------------------------------------------
    assign rdy = (state_q == READY);

    always_comb begin
        if (state_q == CLEARING) begin
            // Sequencer owns the array, no acks go out
            ram_req     = 1'b1;
            ram_wr      = 1'b1;
            ram_ack_en  = 1'b0;
            ram_addr    = clr_addr_q;
            ram_wr_data = mem_pkg::RESET_VAL;
        end else begin
            ram_req     = req && rdy;
            ram_wr      = wr;
            ram_ack_en  = 1'b1;
            ram_addr    = addr;
            ram_wr_data = wr_data;
        end
    end

endmodule : mem_reset_fsm

// ==== hw/mem_ram_core.sv ====
/*
 * Single-port RAM core, read-first
 * Write request pipe ahead of the array, response pipe after the read
 */
`timescale 1ns/1ps

module mem_ram_core (
    input  logic            mem_if,
    input  logic            rst_n,
    input  logic            req,
    input  logic            wr,
    input  logic            ack_en,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::data_t  wr_data,
    output logic            wr_ack,
    output logic            rd_ack,
    output mem_pkg::data_t  rd_data
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    mem_pkg::data_t mem [mem_pkg::DEPTH];

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    mem_pkg::wr_req_t wr_req_in;
    mem_pkg::wr_req_t wr_req_out;
    logic             wr_valid_out;

    assign wr_req_in.ack_en = ack_en;
    assign wr_req_in.addr   = addr;
    assign wr_req_in.data   = wr_data;

    mem_delay_pipe #(
        .T      ( mem_pkg::wr_req_t ),
        .STAGES ( mem_pkg::WR_PIPE_STAGES )
    ) i_wr_pipe (
        .mem_if    ( mem_if ),
        .rst_n     ( rst_n ),
        .in_valid  ( req && wr ),
        .in_data   ( wr_req_in ),
        .out_valid ( wr_valid_out ),
        .out_data  ( wr_req_out )
    );

    // Ack rises on the edge the word lands
    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr_valid_out && wr_req_out.ack_en;
        end
    end

    // --------------------------------------------------
    // Array access
    // --------------------------------------------------
    mem_pkg::data_t rd_word_q;
    logic           rd_valid_q;

    // Read and write share one edge, nonblocking gives read-first
    always_ff @(posedge mem_if) begin
        if (wr_valid_out) begin
            mem[wr_req_out.addr] <= wr_req_out.data;
        end
        if (req && !wr) begin
            rd_word_q <= mem[addr];
        end
    end

    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req && !wr && ack_en;
        end
    end

    // --------------------------------------------------
    // Read response path
    // --------------------------------------------------
    mem_delay_pipe #(
        .T      ( mem_pkg::data_t ),
        .STAGES ( mem_pkg::RD_PIPE_STAGES )
    ) i_rd_pipe (
        .mem_if    ( mem_if ),
        .rst_n     ( rst_n ),
        .in_valid  ( rd_valid_q ),
        .in_data   ( rd_word_q ),
        .out_valid ( rd_ack ),
        .out_data  ( rd_data )
    );

endmodule : mem_ram_core

// ==== hw/mem_ram_sp.sv ====
/*
 * Single-port RAM subsystem with clearing sequence after reset
 */
`timescale 1ns/1ps

module mem_ram_sp (
    input  logic            mem_if,
    input  logic            rst_n,
    input  logic            req,
    input  logic            wr,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::data_t  wr_data,
    output logic            rdy,
    output logic            wr_ack,
    output logic            rd_ack,
    output mem_pkg::data_t  rd_data
);

    // --------------------------------------------------
    // Sequencer to core
    // --------------------------------------------------
    logic           ram_req;
    logic           ram_wr;
    logic           ram_ack_en;
    mem_pkg::addr_t ram_addr;
    mem_pkg::data_t ram_wr_data;

    mem_reset_fsm i_reset_fsm (
        .mem_if      ( mem_if ),
        .rst_n       ( rst_n ),
        .req         ( req ),
        .wr          ( wr ),
        .addr        ( addr ),
        .wr_data     ( wr_data ),
        .rdy         ( rdy ),
        .ram_req     ( ram_req ),
        .ram_wr      ( ram_wr ),
        .ram_ack_en  ( ram_ack_en ),
        .ram_addr    ( ram_addr ),
        .ram_wr_data ( ram_wr_data )
    );

    // Storage and pipelines
    mem_ram_core i_core (
        .mem_if  ( mem_if ),
        .rst_n   ( rst_n ),
        .req     ( ram_req ),
        .wr      ( ram_wr ),
        .ack_en  ( ram_ack_en ),
        .addr    ( ram_addr ),
        .wr_data ( ram_wr_data ),
        .wr_ack  ( wr_ack ),
        .rd_ack  ( rd_ack ),
        .rd_data ( rd_data )
    );

endmodule : mem_ram_sp

// ==== dv/mem_ram_ref_model.sv ====
/*
 * Reference model of the single-port RAM subsystem
 * Tracks clearing, read-first array contents and expected ack timing
 */
`timescale 1ns/1ps

module mem_ram_ref_model (
    input  logic           mem_if,
    input  logic           rst_n,
    input  logic           req,
    input  logic           wr,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::data_t wr_data,
    output logic           exp_wr_ack,
    output logic           exp_rd_ack,
    output mem_pkg::data_t exp_rd_data
);

    localparam int WR_LAT = mem_pkg::WR_LATENCY;
    localparam int RD_LAT = mem_pkg::RD_LATENCY;

    mem_pkg::data_t mem [mem_pkg::DEPTH];
    int             clr_cnt;

    // Write accepted on the previous edge, lands on this one
    logic           pend_vld;
    mem_pkg::addr_t pend_addr;
    mem_pkg::data_t pend_data;

    // Acks in flight, oldest at the top index
    logic           wr_pipe [WR_LAT];
    logic           rd_pipe [RD_LAT];
    mem_pkg::data_t rd_word_pipe [RD_LAT];

    initial begin
        for (int i = 0; i < mem_pkg::DEPTH; i++) begin
            mem[i] = mem_pkg::RESET_VAL;
        end
        clr_cnt  = 0;
        pend_vld = 1'b0;
        for (int k = 0; k < WR_LAT; k++) begin
            wr_pipe[k] = 1'b0;
        end
        for (int k = 0; k < RD_LAT; k++) begin
            rd_pipe[k] = 1'b0;
        end
    end

    always @(posedge mem_if) begin : model_step
        logic           accept;
        mem_pkg::data_t rd_word;

        accept = rst_n && (clr_cnt == mem_pkg::DEPTH) && req;

        // Read-first, then the write from the previous edge lands
        rd_word = mem[addr];
        if (pend_vld) begin
            mem[pend_addr] = pend_data;
        end
        pend_vld = 1'b0;

        if (!rst_n) begin
            // Responses in flight are lost on reset
            clr_cnt = 0;
            for (int k = 0; k < WR_LAT; k++) begin
                wr_pipe[k] = 1'b0;
            end
            for (int k = 0; k < RD_LAT; k++) begin
                rd_pipe[k] = 1'b0;
            end
        end else begin
            if (clr_cnt < mem_pkg::DEPTH) begin
                pend_vld  = 1'b1;
                pend_addr = mem_pkg::addr_t'(clr_cnt);
                pend_data = mem_pkg::RESET_VAL;
                clr_cnt   = clr_cnt + 1;
            end else if (accept && wr) begin
                pend_vld  = 1'b1;
                pend_addr = addr;
                pend_data = wr_data;
            end
            for (int k = WR_LAT - 1; k > 0; k--) begin
                wr_pipe[k] = wr_pipe[k-1];
            end
            for (int k = RD_LAT - 1; k > 0; k--) begin
                rd_pipe[k]      = rd_pipe[k-1];
                rd_word_pipe[k] = rd_word_pipe[k-1];
            end
            wr_pipe[0]      = accept && wr;
            rd_pipe[0]      = accept && !wr;
            rd_word_pipe[0] = rd_word;
        end

        exp_wr_ack  <= wr_pipe[WR_LAT-1];
        exp_rd_ack  <= rd_pipe[RD_LAT-1];
        exp_rd_data <= rd_word_pipe[RD_LAT-1];
    end : model_step

endmodule : mem_ram_ref_model

// ==== dv/mem_ram_sp_tb.sv ====
/*
 * Testbench for the single-port RAM subsystem
 * Random traffic from a fixed seed, checked against the reference model
 */
`timescale 1ns/1ps

module mem_ram_sp_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_CYCLES  = 1800;
    localparam int DRAIN        = 4;
    // Two rounds of reset, clearing and sweep, plus random traffic and margin
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + 2 * mem_pkg::DEPTH + DRAIN)
                                  + RAND_CYCLES + 400;

    logic           mem_if;
    logic           rst_n;
    logic           req;
    logic           wr;
    mem_pkg::addr_t addr;
    mem_pkg::data_t wr_data;
    logic           rdy;
    logic           wr_ack;
    logic           rd_ack;
    mem_pkg::data_t rd_data;

    logic           exp_wr_ack;
    logic           exp_rd_ack;
    mem_pkg::data_t exp_rd_data;

    integer seed = 32'h963f;
    int     cycle_cnt = 0;
    int     rst_high_edges = 0;
    int     rd_checks = 0;
    logic   sweep_active = 1'b0;

    mem_ram_sp i_dut (
        .mem_if  ( mem_if ),
        .rst_n   ( rst_n ),
        .req     ( req ),
        .wr      ( wr ),
        .addr    ( addr ),
        .wr_data ( wr_data ),
        .rdy     ( rdy ),
        .wr_ack  ( wr_ack ),
        .rd_ack  ( rd_ack ),
        .rd_data ( rd_data )
    );

    mem_ram_ref_model i_model (
        .mem_if      ( mem_if ),
        .rst_n       ( rst_n ),
        .req         ( req ),
        .wr          ( wr ),
        .addr        ( addr ),
        .wr_data     ( wr_data ),
        .exp_wr_ack  ( exp_wr_ack ),
        .exp_rd_ack  ( exp_rd_ack ),
        .exp_rd_data ( exp_rd_data )
    );

    initial begin
        mem_if = 1'b0;
        forever #(CLK_PERIOD / 2) mem_if = ~mem_if;
    end

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    always @(posedge mem_if) begin
        rst_high_edges <= rst_n ? rst_high_edges + 1 : 0;
    end

    always @(posedge mem_if) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "stopped by timeout");
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge mem_if) begin
        if (cycle_cnt > 0) begin
            // rdy follows DEPTH clearing edges after reset release
            check_value("rdy", rdy, rst_high_edges >= mem_pkg::DEPTH);
            check_value("wr_ack", wr_ack, exp_wr_ack);
            check_value("rd_ack", rd_ack, exp_rd_ack);
            if (exp_rd_ack) begin
                rd_checks++;
                check_value("rd_data", rd_data, exp_rd_data);
                if (sweep_active) begin
                    check_value("rd_data", rd_data, mem_pkg::RESET_VAL);
                end
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic next_cycle;
        @(posedge mem_if);
        #DRIVE_DLY;
    endtask

    task automatic set_idle;
        req     = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        wr_data = '0;
    endtask

    task automatic set_random;
        int pick;
        pick = $unsigned($random(seed)) % 100;
        req  = (pick < 70);
        wr   = $random(seed) & 1;
        // Half the time stay in a few words to hit back-to-back collisions
        if ($random(seed) & 1) begin
            addr = mem_pkg::addr_t'($unsigned($random(seed)) % 4);
        end else begin
            addr = mem_pkg::addr_t'($random(seed));
        end
        wr_data = mem_pkg::data_t'($random(seed));
    endtask

    task automatic reset_dut(input logic noisy);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            if (noisy) begin
                set_random();
            end else begin
                set_idle();
            end
            next_cycle();
        end
        rst_n = 1'b1;
    endtask

    task automatic wait_ready(input logic noisy);
        next_cycle();
        while (!rdy) begin
            if (noisy) begin
                set_random();
            end else begin
                set_idle();
            end
            next_cycle();
        end
        set_idle();
    endtask

    task automatic read_sweep;
        sweep_active = 1'b1;
        for (int a = 0; a < mem_pkg::DEPTH; a++) begin
            req     = 1'b1;
            wr      = 1'b0;
            addr    = mem_pkg::addr_t'(a);
            wr_data = '0;
            next_cycle();
        end
        set_idle();
        repeat (DRAIN) next_cycle();
        sweep_active = 1'b0;
    endtask

    task automatic random_traffic(input int cycles);
        repeat (cycles) begin
            set_random();
            next_cycle();
        end
        set_idle();
        repeat (DRAIN) next_cycle();
    endtask

    initial begin
        rst_n = 1'b0;
        set_idle();

        reset_dut(1'b0);
        wait_ready(1'b0);
        read_sweep();
        random_traffic(RAND_CYCLES);

        // Second reset with traffic while rdy is low
        reset_dut(1'b1);
        wait_ready(1'b1);
        read_sweep();

        $display("%0d read responses checked", rd_checks);
        $display("Test completed successfully");
        $finish;
    end

endmodule : mem_ram_sp_tb

// ==== filelist.f ====
hw/mem_pkg.sv
hw/mem_delay_pipe.sv
hw/mem_reset_fsm.sv
hw/mem_ram_core.sv
hw/mem_ram_sp.sv
dv/mem_ram_ref_model.sv
dv/mem_ram_sp_tb.sv
